// File: logic/vga_timing_pkg.sv
package vga_timing_pkg;

  // Horizontal raster, 640x480 at 60 Hz
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = 800;

  // Vertical raster
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 11;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 31;
  localparam int V_TOTAL  = 524;

  // Text area inside the border
  localparam int TEXT_LEFT   = 80;
  localparam int TEXT_RIGHT  = 560;
  localparam int TEXT_TOP    = 48;
  localparam int TEXT_BOTTOM = 432;

  // 40x24 cells of 6 pixels, each pixel two clocks wide
  localparam int COLS      = 40;
  localparam int ROWS      = 24;
  localparam int CHAR_PIX  = 6;
  localparam int CELL_CLKS = 12;

  // Frame interrupt pulse length
  localparam int INT_CLKS = 64;

  // Counters to VGA pins
  localparam int PIPE_DELAY = 2;

  typedef logic [9:0] hcount_t;
  typedef logic [9:0] vcount_t;

endpackage

// File: logic/vdp_pkg.sv
package vdp_pkg;

  typedef logic [13:0] vram_addr_t;
  typedef logic [7:0]  vram_data_t;
  typedef logic [3:0]  color_idx_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // MSX colours, entry 0 is transparent and shows as black
  localparam rgb_t PALETTE [16] = '{
    24'h000000,
    24'h010101,
    24'h3eb849,
    24'h74d07d,
    24'h5955e0,
    24'h8076f1,
    24'h993e31,
    24'h65dbef,
    24'hdb6559,
    24'hff897d,
    24'hccc35e,
    24'hded087,
    24'h3aa241,
    24'hb766b5,
    24'h777777,
    24'hffffff
  };

endpackage

// File: logic/wb_if.sv
interface wb_if (
  input logic reset
);

  logic               cyc;
  logic               stb;
  logic               we;
  vdp_pkg::vram_addr_t adr;
  vdp_pkg::vram_data_t dat_w;
  vdp_pkg::vram_data_t dat_r;
  logic               ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // Slave sees the bus reset so ack starts low
  modport slave (
    input  reset, cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

// File: logic/video_timing.sv
module video_timing #(
  parameter int H_TOTAL = 800,
  parameter int V_TOTAL = 524
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    vert_retrace_int,
  output vga_timing_pkg::hcount_t hc,
  output vga_timing_pkg::vcount_t vc,
  output logic                    hs,
  output logic                    vs,
  output logic                    de,
  output logic                    border,
  output logic                    n_int
);

  localparam int HS_START = vga_timing_pkg::H_ACTIVE + vga_timing_pkg::H_FRONT;
  localparam int HS_END   = HS_START + vga_timing_pkg::H_SYNC;
  localparam int VS_START = vga_timing_pkg::V_ACTIVE + vga_timing_pkg::V_FRONT;
  localparam int VS_END   = VS_START + vga_timing_pkg::V_SYNC;

  logic [5:0] int_cnt;
  logic       in_text;

  assign in_text = (hc >= vga_timing_pkg::TEXT_LEFT) && (hc < vga_timing_pkg::TEXT_RIGHT) &&
                   (vc >= vga_timing_pkg::TEXT_TOP) && (vc < vga_timing_pkg::TEXT_BOTTOM);

  // Raster counters
  always_ff @(posedge clk) begin
    if (reset) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == H_TOTAL - 1) begin
      hc <= '0;
      vc <= (vc == V_TOTAL - 1) ? '0 : vc + 1'b1;
    end else begin
      hc <= hc + 1'b1;
    end
  end

  // Flags lag the counters by one clock
  always_ff @(posedge clk) begin
    if (reset) begin
      hs     <= 1'b1;
      vs     <= 1'b1;
      de     <= 1'b0;
      border <= 1'b1;
    end else begin
      hs     <= !(hc >= HS_START && hc < HS_END);
      vs     <= !(vc >= VS_START && vc < VS_END);
      de     <= (hc < vga_timing_pkg::H_ACTIVE) && (vc < vga_timing_pkg::V_ACTIVE);
      border <= !in_text;
    end
  end

  // Frame interrupt, low for INT_CLKS cycles from the start of vertical sync
  always_ff @(posedge clk) begin
    if (reset) begin
      n_int   <= 1'b1;
      int_cnt <= '0;
    end else if (!n_int) begin
      int_cnt <= int_cnt + 1'b1;
      if (int_cnt == 6'(vga_timing_pkg::INT_CLKS - 1)) begin
        n_int <= 1'b1;
      end
    end else if (vert_retrace_int && hc == HS_START && vc == VS_START) begin
      n_int   <= 1'b0;
      int_cnt <= '0;
    end
  end

endmodule

// File: logic/vram.sv
module vram (
  input  logic                clk,
  wb_if.slave                 bus,
  input  vdp_pkg::vram_addr_t vid_addr,
  output vdp_pkg::vram_data_t vid_data
);

  localparam int DEPTH = 2 ** $bits(vdp_pkg::vram_addr_t);

  vdp_pkg::vram_data_t mem [DEPTH];

  logic req;

  // New request only when no ack is pending
  assign req = bus.cyc && bus.stb && !bus.ack;

  // Wishbone port, ack one cycle after the request
  always_ff @(posedge clk) begin
    if (bus.reset) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req && bus.we) begin
      mem[bus.adr] <= bus.dat_w;
    end
    if (req) begin
      bus.dat_r <= mem[bus.adr];
    end
  end

  // Video read port, data one clock after the address
  always_ff @(posedge clk) begin
    vid_data <= mem[vid_addr];
  end

endmodule

// File: logic/text_fetch.sv
module text_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  vga_timing_pkg::hcount_t hc,
  input  vga_timing_pkg::vcount_t vc,
  input  logic                    video_on,
  input  vdp_pkg::vram_addr_t     name_table_addr,
  input  vdp_pkg::vram_addr_t     font_addr,
  input  vdp_pkg::color_idx_t     text_color,
  input  vdp_pkg::color_idx_t     back_color,
  input  vdp_pkg::vram_data_t     vid_data,
  output vdp_pkg::vram_addr_t     vid_addr,
  output vdp_pkg::color_idx_t     pix_idx
);

  // Fetch runs one cell ahead of the displayed cell
  localparam int FETCH_START = vga_timing_pkg::TEXT_LEFT - vga_timing_pkg::CELL_CLKS;

  logic [3:0]          sub;
  logic [5:0]          fcol;
  logic [7:0]          row;
  logic [4:0]          char_row;
  logic [2:0]          line;
  logic [2:0]          pix;
  logic                in_area;
  logic                font_bit;
  vdp_pkg::vram_data_t next_font;
  vdp_pkg::vram_data_t font_line;

  assign row      = 8'((vc - vga_timing_pkg::TEXT_TOP) >> 1);
  assign char_row = row[7:3];
  assign line     = row[2:0];
  assign pix      = sub[3:1];
  assign font_bit = font_line[3'd7 - pix];

  assign in_area = (hc >= vga_timing_pkg::TEXT_LEFT) && (hc < vga_timing_pkg::TEXT_RIGHT) &&
                   (vc >= vga_timing_pkg::TEXT_TOP) && (vc < vga_timing_pkg::TEXT_BOTTOM);

  // Clock within the cell and the column being fetched
  always_ff @(posedge clk) begin
    if (reset) begin
      sub  <= '0;
      fcol <= '0;
    end else if (hc == FETCH_START - 1) begin
      sub  <= '0;
      fcol <= '0;
    end else if (sub == 4'(vga_timing_pkg::CELL_CLKS - 1)) begin
      sub  <= '0;
      fcol <= fcol + 1'b1;
    end else begin
      sub <= sub + 1'b1;
    end
  end

  // Name read at clock 0, pattern read at clock 2, data stored at clock 4
  always_ff @(posedge clk) begin
    case (sub)
      4'd0: begin
        vid_addr <= name_table_addr + 14'(char_row * vga_timing_pkg::COLS) + 14'(fcol);
      end
      4'd2: begin
        vid_addr <= font_addr + {3'b000, vid_data, line};
      end
      4'd4: begin
        next_font <= vid_data;
      end
      default: begin
      end
    endcase
    // Line for the next cell takes over on its first clock
    if (sub == 4'(vga_timing_pkg::CELL_CLKS - 1)) begin
      font_line <= next_font;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_idx <= '0;
    end else if (in_area && video_on && font_bit) begin
      pix_idx <= text_color;
    end else begin
      pix_idx <= back_color;
    end
  end

endmodule

// File: logic/pixel_output.sv
module pixel_output (
  input  logic                clk,
  input  logic                reset,
  input  vdp_pkg::color_idx_t pix_idx,
  input  logic                border,
  input  logic                hs,
  input  logic                vs,
  input  logic                de,
  output logic [7:0]          vga_r,
  output logic [7:0]          vga_g,
  output logic [7:0]          vga_b,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic                vga_de
);

  vdp_pkg::rgb_t color;

  // Border pixels already arrive as the back colour index
  always_comb begin
    if (!de) begin
      color = '0;
    end else begin
      color = vdp_pkg::PALETTE[pix_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_de <= 1'b0;
    end else begin
      vga_r  <= color.r;
      vga_g  <= color.g;
      vga_b  <= color.b;
      vga_hs <= hs;
      vga_vs <= vs;
      vga_de <= de;
    end
  end

endmodule

// File: logic/vdp_top.sv
module vdp_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  vdp_pkg::vram_addr_t wb_adr,
  input  vdp_pkg::vram_data_t wb_dat_w,
  output vdp_pkg::vram_data_t wb_dat_r,
  output logic                wb_ack,
  input  vdp_pkg::vram_addr_t name_table_addr,
  input  vdp_pkg::vram_addr_t font_addr,
  input  vdp_pkg::color_idx_t text_color,
  input  vdp_pkg::color_idx_t back_color,
  input  logic                video_on,
  input  logic                vert_retrace_int,
  output logic [7:0]          vga_r,
  output logic [7:0]          vga_g,
  output logic [7:0]          vga_b,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic                vga_de,
  output logic                n_int
);

  vga_timing_pkg::hcount_t hc;
  vga_timing_pkg::vcount_t vc;
  logic                    hs;
  logic                    vs;
  logic                    de;
  logic                    border;
  vdp_pkg::vram_addr_t     vid_addr;
  vdp_pkg::vram_data_t     vid_data;
  vdp_pkg::color_idx_t     pix_idx;

  wb_if bus (.reset(reset));

  // CPU side of the bus
  assign bus.cyc   = wb_cyc;
  assign bus.stb   = wb_stb;
  assign bus.we    = wb_we;
  assign bus.adr   = wb_adr;
  assign bus.dat_w = wb_dat_w;
  assign wb_dat_r  = bus.dat_r;
  assign wb_ack    = bus.ack;

  video_timing #(
    .H_TOTAL(vga_timing_pkg::H_TOTAL),
    .V_TOTAL(vga_timing_pkg::V_TOTAL)
  ) u_video_timing (
    .clk              (clk),
    .reset            (reset),
    .vert_retrace_int (vert_retrace_int),
    .hc               (hc),
    .vc               (vc),
    .hs               (hs),
    .vs               (vs),
    .de               (de),
    .border           (border),
    .n_int            (n_int)
  );

  vram u_vram (
    .clk      (clk),
    .bus      (bus.slave),
    .vid_addr (vid_addr),
    .vid_data (vid_data)
  );

  text_fetch u_text_fetch (
    .clk             (clk),
    .reset           (reset),
    .hc              (hc),
    .vc              (vc),
    .video_on        (video_on),
    .name_table_addr (name_table_addr),
    .font_addr       (font_addr),
    .text_color      (text_color),
    .back_color      (back_color),
    .vid_data        (vid_data),
    .vid_addr        (vid_addr),
    .pix_idx         (pix_idx)
  );

  pixel_output u_pixel_output (
    .clk     (clk),
    .reset   (reset),
    .pix_idx (pix_idx),
    .border  (border),
    .hs      (hs),
    .vs      (vs),
    .de      (de),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_de  (vga_de)
  );

endmodule

// File: testbench/vdp_assertions.sv
module vdp_assertions (
  input logic clk,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic hs
);

  int unsigned hs_low_len;
  int unsigned fail_count = 0;

  // Length of the current horizontal sync pulse
  always_ff @(posedge clk) begin
    if (reset || hs) begin
      hs_low_len <= 0;
    end else begin
      hs_low_len <= hs_low_len + 1;
    end
  end

  ack_needs_request: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(cyc && stb))
    else begin
      fail_count++;
      $error("ack rose without a cyc and stb request");
    end

  ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
    ack |=> !ack)
    else begin
      fail_count++;
      $error("ack stayed high for more than one cycle");
    end

  hsync_width: assert property (@(posedge clk) disable iff (reset)
    $rose(hs) |-> hs_low_len == vga_timing_pkg::H_SYNC)
    else begin
      fail_count++;
      $error("hsync low pulse was %0d cycles", hs_low_len);
    end

endmodule

// Bus of the VRAM slave port and the hsync flag from video_timing
bind vdp_top vdp_assertions u_vdp_assertions (
  .clk   (clk),
  .reset (reset),
  .cyc   (bus.cyc),
  .stb   (bus.stb),
  .ack   (bus.ack),
  .hs    (hs)
);

// File: testbench/tb_vdp.sv
module tb_vdp;

  localparam int H_TOTAL   = vga_timing_pkg::H_TOTAL;
  localparam int H_ACTIVE  = vga_timing_pkg::H_ACTIVE;
  localparam int V_ACTIVE  = vga_timing_pkg::V_ACTIVE;
  localparam int FRAME     = H_TOTAL * vga_timing_pkg::V_TOTAL;
  localparam int HS_START  = H_ACTIVE + vga_timing_pkg::H_FRONT;
  localparam int VS_START  = V_ACTIVE + vga_timing_pkg::V_FRONT;
  localparam int LEFT      = vga_timing_pkg::TEXT_LEFT;
  localparam int TOP       = vga_timing_pkg::TEXT_TOP;
  localparam int CELLS     = vga_timing_pkg::COLS * vga_timing_pkg::ROWS;
  // Counter position one clock after the start of vertical sync
  localparam int INT_START = HS_START + VS_START * H_TOTAL + 1;
  localparam int ENTRIES   = 5;
  localparam int RW_CHECKS = 16;
  localparam int SETTLE    = 32;
  // Every bus access takes three clocks and four are allowed here
  localparam int LIMIT = ENTRIES * (FRAME + 4 * (CELLS + 8) + SETTLE + 2)
                         + 8 * RW_CHECKS + 10000;
  localparam vdp_pkg::vram_addr_t NAME_BASE = 14'h1800;
  localparam vdp_pkg::vram_addr_t FONT_BASE = 14'h0800;

  typedef struct packed {
    vdp_pkg::vram_data_t code;
    vdp_pkg::vram_data_t font;
    vdp_pkg::color_idx_t text;
    vdp_pkg::color_idx_t back;
    logic                retrace_int;
    logic                video_on;
  } entry_t;

  // Char code, font byte, text colour, back colour, interrupt enable, video on
  localparam entry_t TABLE [ENTRIES] = '{
    '{8'h41, 8'ha5, 4'd15, 4'd4,  1'b1, 1'b1},
    '{8'h00, 8'h3c, 4'd0,  4'd7,  1'b0, 1'b1},
    '{8'hff, 8'hf0, 4'd2,  4'd0,  1'b1, 1'b1},
    '{8'h7e, 8'hff, 4'd9,  4'd13, 1'b1, 1'b0},
    '{8'h18, 8'h81, 4'd11, 4'd1,  1'b0, 1'b1}
  };

  logic                clk;
  logic                reset;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  vdp_pkg::vram_addr_t wb_adr;
  vdp_pkg::vram_data_t wb_dat_w;
  vdp_pkg::vram_data_t wb_dat_r;
  logic                wb_ack;
  vdp_pkg::vram_addr_t name_table_addr;
  vdp_pkg::vram_addr_t font_addr;
  vdp_pkg::color_idx_t text_color;
  vdp_pkg::color_idx_t back_color;
  logic                video_on;
  logic                vert_retrace_int;
  logic [7:0]          vga_r;
  logic [7:0]          vga_g;
  logic [7:0]          vga_b;
  logic                vga_hs;
  logic                vga_vs;
  logic                vga_de;
  logic                n_int;

  // Model state
  vdp_pkg::vram_data_t shadow [2 ** 14];
  vdp_pkg::color_idx_t cur_text;
  vdp_pkg::color_idx_t cur_back;
  logic                cur_retrace;
  logic                cur_von;
  int                  run_cnt;
  int                  cycles;
  int                  pos_h = -1;
  int                  pos_v = -1;

  vdp_top u_vdp_top (
    .clk              (clk),
    .reset            (reset),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .name_table_addr  (name_table_addr),
    .font_addr        (font_addr),
    .text_color       (text_color),
    .back_color       (back_color),
    .video_on         (video_on),
    .vert_retrace_int (vert_retrace_int),
    .vga_r            (vga_r),
    .vga_g            (vga_g),
    .vga_b            (vga_b),
    .vga_hs           (vga_hs),
    .vga_vs           (vga_vs),
    .vga_de           (vga_de),
    .n_int            (n_int)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Clocks since reset release match the raster counters' linear position
  always @(posedge clk) begin
    if (reset) begin
      run_cnt <= 0;
    end else begin
      run_cnt <= run_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
      abort_run();
    end
  end

  // Stop at the first failed bound assertion
  always @(negedge clk) begin
    if (u_vdp_top.u_vdp_assertions.fail_count != 0) begin
      $display("A bound assertion on the bus or the sync signals failed");
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rgb(vdp_pkg::rgb_t got, vdp_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("ERR %0t: rgb %06h, expected %06h at h=%0d v=%0d",
               $time, got, exp, pos_h, pos_v);
      abort_run();
    end
  endtask

  task automatic check_byte(vdp_pkg::vram_data_t got, vdp_pkg::vram_data_t exp,
                            vdp_pkg::vram_addr_t adr);
    if (got !== exp) begin
      $display("ERR %0t: read %02h from %04h, expected %02h", $time, got, adr, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      if (pos_h >= 0) begin
        $display("ERR %0t: %s is %b, expected %b at h=%0d v=%0d",
                 $time, what, got, exp, pos_h, pos_v);
      end else begin
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
      abort_run();
    end
  endtask

  // One Wishbone classic cycle with ack expected one clock after stb
  task automatic bus_access(logic we, vdp_pkg::vram_addr_t adr, vdp_pkg::vram_data_t wdata,
                            output vdp_pkg::vram_data_t rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      $display("VRAM gave no ack within 16 clocks for address %04h", adr);
      abort_run();
    end
    check_bit(waited == 2, 1'b1, "ack one clock after stb");
    rdata = wb_dat_r;
    if (we) begin
      shadow[adr] = wdata;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic test_readback();
    vdp_pkg::vram_addr_t adr;
    vdp_pkg::vram_data_t data;
    vdp_pkg::vram_data_t rd;
    for (int i = 0; i < RW_CHECKS; i++) begin
      adr  = 14'($urandom);
      data = 8'($urandom);
      bus_access(1'b1, adr, data, rd);
      bus_access(1'b0, adr, 8'h00, rd);
      check_byte(rd, data, adr);
    end
  endtask

  task automatic write_screen(entry_t e);
    vdp_pkg::vram_data_t unused;
    vdp_pkg::vram_data_t line_byte;
    for (int i = 0; i < CELLS; i++) begin
      bus_access(1'b1, NAME_BASE + 14'(i), e.code, unused);
    end
    // Even font lines carry the table byte and odd lines a random fill
    for (int l = 0; l < 8; l++) begin
      line_byte = (l % 2 == 0) ? e.font : 8'($urandom);
      bus_access(1'b1, FONT_BASE + 14'(8 * int'(e.code) + l), line_byte, unused);
    end
  endtask

  function automatic vdp_pkg::rgb_t expected_rgb(int h, int v);
    int                  row;
    vdp_pkg::vram_data_t code;
    vdp_pkg::vram_data_t pattern;
    vdp_pkg::color_idx_t idx;
    idx = cur_back;
    if (h >= LEFT && h < vga_timing_pkg::TEXT_RIGHT && v >= TOP &&
        v < vga_timing_pkg::TEXT_BOTTOM && cur_von) begin
      row     = (v - TOP) / 2;
      code    = shadow[14'(NAME_BASE + 40 * (row / 8) + (h - LEFT) / 12)];
      pattern = shadow[14'(FONT_BASE + 8 * int'(code) + row % 8)];
      if (pattern[7 - ((h - LEFT) / 2) % 6]) begin
        idx = cur_text;
      end
    end
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      return '0;
    end
    // Index 0 is transparent and shows black
    return (idx == 0) ? '0 : vdp_pkg::PALETTE[idx];
  endfunction

  // Compares every output for one full frame of raster positions
  task automatic check_frame();
    int            pos;
    int            cnt_pos;
    logic          exp_int;
    vdp_pkg::rgb_t got;
    for (int n = 0; n < FRAME; n++) begin
      @(negedge clk);
      pos     = (run_cnt - vga_timing_pkg::PIPE_DELAY) % FRAME;
      cnt_pos = run_cnt % FRAME;
      pos_h   = pos % H_TOTAL;
      pos_v   = pos / H_TOTAL;
      got     = {vga_r, vga_g, vga_b};
      check_rgb(got, expected_rgb(pos_h, pos_v));
      check_bit(vga_de, pos_h < H_ACTIVE && pos_v < V_ACTIVE, "vga_de");
      check_bit(vga_hs, !(pos_h >= HS_START && pos_h < HS_START + vga_timing_pkg::H_SYNC),
                "vga_hs");
      check_bit(vga_vs, !(pos_v >= VS_START && pos_v < VS_START + vga_timing_pkg::V_SYNC),
                "vga_vs");
      exp_int = !(cur_retrace && cnt_pos >= INT_START &&
                  cnt_pos < INT_START + vga_timing_pkg::INT_CLKS);
      check_bit(n_int, exp_int, "n_int");
    end
    pos_h = -1;
  endtask

  initial begin
    void'($urandom(32'he3db));
    cycles           = 0;
    reset            = 1'b1;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_w         = '0;
    name_table_addr  = NAME_BASE;
    font_addr        = FONT_BASE;
    text_color       = '0;
    back_color       = '0;
    video_on         = 1'b0;
    vert_retrace_int = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_readback();
    for (int e = 0; e < ENTRIES; e++) begin
      @(posedge clk);
      text_color       <= TABLE[e].text;
      back_color       <= TABLE[e].back;
      video_on         <= TABLE[e].video_on;
      vert_retrace_int <= TABLE[e].retrace_int;
      cur_text    = TABLE[e].text;
      cur_back    = TABLE[e].back;
      cur_von     = TABLE[e].video_on;
      cur_retrace = TABLE[e].retrace_int;
      write_screen(TABLE[e]);
      // Let the fetch pipeline pick up the new screen
      repeat (SETTLE) @(posedge clk);
      check_frame();
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// File: project.f
logic/vga_timing_pkg.sv
logic/vdp_pkg.sv
logic/wb_if.sv
logic/video_timing.sv
logic/vram.sv
logic/text_fetch.sv
logic/pixel_output.sv
logic/vdp_top.sv
testbench/vdp_assertions.sv
testbench/tb_vdp.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_vdp
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
